//--- verilog/board_pkg.sv
// Board configuration constants for the network card shell

package board_pkg;

    // Network ports, one RGB status LED each
    localparam integer PORT_CNT = 4;

    // Core clock and serial rate
    localparam integer CLK_FREQ_HZ = 125_000_000;
    localparam integer UART_BAUD = 115_200;

    // Clock cycles per UART bit, rounded to the nearest integer
    localparam integer UART_PRESCALE = (CLK_FREQ_HZ + UART_BAUD / 2) / UART_BAUD;

    // Flops in the reset synchronizer
    localparam integer RST_SYNC_LEN = 4;

    // Blink half-periods in clock cycles
    // 1 Hz on the board
    localparam integer BLINK_HALF_HW = 62_500_000;
    // Short enough to watch several phases in simulation
    localparam integer BLINK_HALF_SIM = 64;

endpackage

//--- verilog/led_pkg.sv
// Port LED colour types and the layout of the host command byte

package led_pkg;

    // One RGB status LED
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    // Command byte bits 7..2
    // bits 7..6 port, bit 5 blink, bits 4..2 red, green, blue
    typedef struct packed {
        logic [1:0] port;
        logic       blink;
        rgb_t       color;
    } port_cmd_t;

    // Stored status of one port
    typedef struct packed {
        rgb_t color;
        logic blink;
    } port_state_t;

    // Reserved bits 1..0 must be zero in a valid command
    localparam logic [7:0] CMD_RSVD_MASK = 8'h03;

    // Reply to a malformed command
    localparam logic [7:0] NAK_BYTE = 8'hFF;

endpackage

//--- verilog/sync_reset.sv
// Reset synchronizer with asynchronous assert and synchronous release

`resetall
`timescale 1ns/10ps
`default_nettype none

module sync_reset (
    input  logic clk_125mhz,
    input  logic rst_n,
    output logic rst_out_n
);

    logic [board_pkg::RST_SYNC_LEN-1:0] sync_reg;

    // Ones shift in from the bottom once the board reset is gone
    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            sync_reg <= '0;
        end else begin
            sync_reg <= {sync_reg[board_pkg::RST_SYNC_LEN-2:0], 1'b1};
        end
    end

    assign rst_out_n = sync_reg[board_pkg::RST_SYNC_LEN-1];

endmodule

`resetall

//--- verilog/uart_rx.sv
// UART 8N1 receiver, samples each bit at its middle and strobes the byte

`resetall
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
    input  logic       clk_125mhz,
    input  logic       rst_n,
    input  logic       uart_rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef logic [$clog2(board_pkg::UART_PRESCALE)-1:0] cnt_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state;
    cnt_t       bit_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift_reg;
    logic [1:0] rxd_sync;
    logic       rxd_last;
    logic       rxd;

    // Two flop synchronizer for the asynchronous line
    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            rxd_sync <= 2'b11;
            rxd_last <= 1'b1;
        end else begin
            rxd_sync <= {rxd_sync[0], uart_rxd};
            rxd_last <= rxd_sync[1];
        end
    end

    assign rxd = rxd_sync[1];

    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (bit_cnt != '0) begin
                bit_cnt <= bit_cnt - cnt_t'(1);
            end
            case (state)
                RX_IDLE: begin
                    // Falling edge starts a frame, wait half a bit
                    if (rxd_last && !rxd) begin
                        state   <= RX_START;
                        bit_cnt <= cnt_t'(board_pkg::UART_PRESCALE / 2 - 1);
                    end
                end
                RX_START: begin
                    if (bit_cnt == '0) begin
                        // Glitch if the line went back high
                        if (!rxd) begin
                            state   <= RX_DATA;
                            bit_idx <= '0;
                            bit_cnt <= cnt_t'(board_pkg::UART_PRESCALE - 1);
                        end else begin
                            state <= RX_IDLE;
                        end
                    end
                end
                RX_DATA: begin
                    if (bit_cnt == '0) begin
                        bit_idx <= bit_idx + 3'd1;
                        bit_cnt <= cnt_t'(board_pkg::UART_PRESCALE - 1);
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_cnt == '0) begin
                        // Framing error drops the byte silently
                        rx_valid <= rxd;
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_125mhz) begin
        if (state == RX_DATA && bit_cnt == '0) begin
            shift_reg <= {rxd, shift_reg[7:1]};
        end
        if (state == RX_STOP && bit_cnt == '0) begin
            rx_data <= shift_reg;
        end
    end

    a_rx_valid_single: assert property (
        @(posedge clk_125mhz) disable iff (!rst_n) rx_valid |=> !rx_valid
    );

endmodule

`resetall

//--- verilog/uart_tx.sv
// UART 8N1 transmitter, sends one byte per start strobe

`resetall
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
    input  logic       clk_125mhz,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       uart_txd,
    output logic       tx_busy
);

    typedef logic [$clog2(board_pkg::UART_PRESCALE)-1:0] cnt_t;

    cnt_t       bit_cnt;
    logic [3:0] bits_left;
    // Data bits followed by the stop bit
    logic [8:0] shift_reg;

    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            uart_txd  <= 1'b1;
            tx_busy   <= 1'b0;
            bit_cnt   <= '0;
            bits_left <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Start bit goes out right away
                uart_txd  <= 1'b0;
                tx_busy   <= 1'b1;
                bit_cnt   <= cnt_t'(board_pkg::UART_PRESCALE - 1);
                bits_left <= 4'd9;
            end
        end else if (bit_cnt != '0) begin
            bit_cnt <= bit_cnt - cnt_t'(1);
        end else if (bits_left == '0) begin
            // Stop bit has run its full length
            tx_busy <= 1'b0;
        end else begin
            uart_txd  <= shift_reg[0];
            bits_left <= bits_left - 4'd1;
            bit_cnt   <= cnt_t'(board_pkg::UART_PRESCALE - 1);
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (!tx_busy && tx_start) begin
            shift_reg <= {1'b1, tx_data};
        end else if (tx_busy && bit_cnt == '0) begin
            shift_reg <= {1'b1, shift_reg[8:1]};
        end
    end

    // The core has no back-pressure, a start while busy would be lost
    a_no_start_busy: assert property (
        @(posedge clk_125mhz) disable iff (!rst_n) tx_start |-> !tx_busy
    );

endmodule

`resetall

//--- verilog/fpga_core.sv
// Control core: UART command decode, port LED status and blink, echo or NAK reply

`resetall
`timescale 1ns/10ps
`default_nettype none

module fpga_core #(
    parameter logic SIM = 1'b0
) (
    input  logic                            clk_125mhz,
    input  logic                            rst_n,
    input  logic                            uart_rxd,
    output logic                            uart_txd,
    output logic [board_pkg::PORT_CNT-1:0]  port_led_stat_r,
    output logic [board_pkg::PORT_CNT-1:0]  port_led_stat_g,
    output logic [board_pkg::PORT_CNT-1:0]  port_led_stat_b
);

    localparam integer BLINK_HALF = SIM ? board_pkg::BLINK_HALF_SIM : board_pkg::BLINK_HALF_HW;

    typedef logic [$clog2(BLINK_HALF)-1:0] blink_cnt_t;

    logic [7:0]             rx_data;
    logic                   rx_valid;
    logic [7:0]             tx_data;
    logic                   tx_start;
    logic                   tx_busy;
    led_pkg::port_cmd_t     cmd;
    logic                   cmd_bad;
    led_pkg::port_state_t   port_state [board_pkg::PORT_CNT];
    logic [board_pkg::PORT_CNT-1:0] port_on;
    blink_cnt_t             blink_cnt;
    logic                   blink_phase;

    uart_rx uart_rx_inst (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .uart_rxd   (uart_rxd),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid)
    );

    uart_tx uart_tx_inst (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .uart_txd   (uart_txd),
        .tx_busy    (tx_busy)
    );

    assign cmd     = led_pkg::port_cmd_t'(rx_data[7:2]);
    assign cmd_bad = (rx_data & led_pkg::CMD_RSVD_MASK) != 8'h00;

    // State update and reply start, one cycle after the strobe
    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < board_pkg::PORT_CNT; i++) begin
                port_state[i] <= '0;
            end
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (rx_valid) begin
                // Reply is dropped while the transmitter is still sending
                tx_start <= !tx_busy;
                if (!cmd_bad) begin
                    port_state[cmd.port].color <= cmd.color;
                    port_state[cmd.port].blink <= cmd.blink;
                end
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rx_valid) begin
            tx_data <= cmd_bad ? led_pkg::NAK_BYTE : rx_data;
        end
    end

    // Shared blink phase for all ports
    always_ff @(posedge clk_125mhz or negedge rst_n) begin
        if (!rst_n) begin
            blink_cnt   <= '0;
            blink_phase <= 1'b0;
        end else if (blink_cnt == blink_cnt_t'(BLINK_HALF - 1)) begin
            blink_cnt   <= '0;
            blink_phase <= !blink_phase;
        end else begin
            blink_cnt <= blink_cnt + blink_cnt_t'(1);
        end
    end

    always_comb begin
        for (int i = 0; i < board_pkg::PORT_CNT; i++) begin
            // Steady ports stay lit, blinking ones only in the high phase
            port_on[i] = !port_state[i].blink || blink_phase;
            port_led_stat_r[i] = port_state[i].color.r && port_on[i];
            port_led_stat_g[i] = port_state[i].color.g && port_on[i];
            port_led_stat_b[i] = port_state[i].color.b && port_on[i];
        end
    end

    for (genvar i = 0; i < board_pkg::PORT_CNT; i++) begin : g_state_chk
        a_state_on_cmd: assert property (
            @(posedge clk_125mhz) disable iff (!rst_n)
            !$stable(port_state[i]) |-> $past(rx_valid)
        );
    end

endmodule

`resetall

//--- verilog/fpga.sv
// Board top of the network card, ties reset synchronizer and core to the pins

`resetall
`timescale 1ns/10ps
`default_nettype none

module fpga #(
    parameter logic SIM = 1'b0
) (
    input  logic                            clk_125mhz,
    input  logic                            rst_n,
    input  logic                            uart_rxd,
    output logic                            uart_txd,
    output logic [board_pkg::PORT_CNT-1:0]  dsfp_led_r,
    output logic [board_pkg::PORT_CNT-1:0]  dsfp_led_g,
    output logic [board_pkg::PORT_CNT-1:0]  dsfp_led_b
);

    // Local core reset, released in step with the clock
    logic rst_core_n;

    sync_reset sync_reset_inst (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .rst_out_n  (rst_core_n)
    );

    fpga_core #(
        .SIM(SIM)
    ) core_inst (
        .clk_125mhz      (clk_125mhz),
        .rst_n           (rst_core_n),
        .uart_rxd        (uart_rxd),
        .uart_txd        (uart_txd),
        // Status LEDs of the optical cages
        .port_led_stat_r (dsfp_led_r),
        .port_led_stat_g (dsfp_led_g),
        .port_led_stat_b (dsfp_led_b)
    );

endmodule

`resetall

//--- dv/tb_clk_gen.sv
// Testbench clock and reset source, 8 ns clock with a 4 cycle board reset
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_125mhz,
    output logic rst_n
);

    localparam real HALF_PERIOD = 4.0;
    localparam integer RST_CYCLES = 4;

    initial begin
        clk_125mhz = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_125mhz = ~clk_125mhz;
        end
    end

    // Board reset released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_125mhz);
        rst_n <= 1'b1;
    end

endmodule

//--- dv/tb_fpga.sv
// Testbench top where a UART host model sends LED commands from a data file to the board top
`timescale 1ns/10ps

module tb_fpga;

    localparam integer BIT_CYC = board_pkg::UART_PRESCALE;
    localparam integer PORTS = board_pkg::PORT_CNT;
    localparam integer WINDOW = 2 * board_pkg::BLINK_HALF_SIM + 2;
    localparam integer CLK_PERIOD_NS = 8;

    logic             clk_125mhz;
    logic             rst_n;
    logic             uart_rxd;
    logic             uart_txd;
    logic [PORTS-1:0] led_r;
    logic [PORTS-1:0] led_g;
    logic [PORTS-1:0] led_b;

    // Tests as read from the data file
    string            t_name [$];
    logic [7:0]       t_cmd [$];
    logic [7:0]       t_reply [$];
    logic [PORTS-1:0] t_r [$];
    logic [PORTS-1:0] t_g [$];
    logic [PORTS-1:0] t_b [$];
    logic [PORTS-1:0] t_blink [$];

    // Port state model with one bit per port
    logic [PORTS-1:0] m_r;
    logic [PORTS-1:0] m_g;
    logic [PORTS-1:0] m_b;
    logic [PORTS-1:0] m_blink;

    int          pass_cnt;
    int          fail_cnt;
    int          wd_ns;
    logic        test_ok;
    logic        loaded = 1'b0;

    tb_clk_gen clk_gen (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n)
    );

    fpga #(
        .SIM(1'b1)
    ) dut (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .uart_rxd   (uart_rxd),
        .uart_txd   (uart_txd),
        .dsfp_led_r (led_r),
        .dsfp_led_g (led_g),
        .dsfp_led_b (led_b)
    );

    task automatic load_tests();
        int               fd;
        int               n;
        string            line;
        string            name;
        logic [7:0]       cmd;
        logic [7:0]       reply;
        logic [PORTS-1:0] r;
        logic [PORTS-1:0] g;
        logic [PORTS-1:0] b;
        logic [PORTS-1:0] blink;
        fd = $fopen("dv/fpga_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file dv/fpga_testdata.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h", name, cmd, reply, r, g, b, blink);
                    if (n == 7) begin
                        t_name.push_back(name);
                        t_cmd.push_back(cmd);
                        t_reply.push_back(reply);
                        t_r.push_back(r);
                        t_g.push_back(g);
                        t_b.push_back(b);
                        t_blink.push_back(blink);
                    end else begin
                        $display("Test data line could not be parsed: %s", line);
                        fail_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_bits(input int bits);
        repeat (bits * BIT_CYC) @(posedge clk_125mhz);
    endtask

    // Host side 8N1 frame sent LSB first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_125mhz);
            uart_rxd <= frame[i];
            repeat (BIT_CYC - 1) @(posedge clk_125mhz);
        end
    endtask

    // Waits up to limit cycles for a start bit and then samples mid-bit
    task automatic receive_byte(input int limit, output logic started, output logic framed,
                                output logic [7:0] data);
        int waited;
        started = 1'b0;
        framed = 1'b0;
        data = '0;
        waited = 0;
        while (uart_txd !== 1'b0 && waited < limit) begin
            @(posedge clk_125mhz);
            waited++;
        end
        if (uart_txd === 1'b0) begin
            started = 1'b1;
            repeat (BIT_CYC / 2) @(posedge clk_125mhz);
            framed = (uart_txd === 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CYC) @(posedge clk_125mhz);
                data[i] = uart_txd;
            end
            repeat (BIT_CYC) @(posedge clk_125mhz);
            framed = framed && (uart_txd === 1'b1);
        end
    endtask

    // Steady ports hold their colour while blinking ones show colour and dark
    task automatic check_leds(input string name, input logic [PORTS-1:0] exp_r,
                              input logic [PORTS-1:0] exp_g, input logic [PORTS-1:0] exp_b,
                              input logic [PORTS-1:0] exp_blink);
        logic [PORTS-1:0] saw_on;
        logic [PORTS-1:0] saw_off;
        logic [PORTS-1:0] reported;
        logic [2:0]       exp_rgb;
        logic [2:0]       act_rgb;
        saw_on = '0;
        saw_off = '0;
        reported = '0;
        for (int c = 0; c < WINDOW; c++) begin
            @(negedge clk_125mhz);
            for (int p = 0; p < PORTS; p++) begin
                exp_rgb = {exp_r[p], exp_g[p], exp_b[p]};
                act_rgb = {led_r[p], led_g[p], led_b[p]};
                if (exp_blink[p]) begin
                    saw_on[p] = saw_on[p] || (act_rgb == exp_rgb);
                    saw_off[p] = saw_off[p] || (act_rgb == 3'b000);
                end else begin
                    assert (act_rgb == exp_rgb || reported[p]) else begin
                        $display("Error %s: port %0d LED expected %b actual %b",
                                 name, p, exp_rgb, act_rgb);
                        reported[p] = 1'b1;
                        test_ok = 1'b0;
                    end
                end
            end
        end
        for (int p = 0; p < PORTS; p++) begin
            assert (!exp_blink[p] || (saw_on[p] && saw_off[p])) else begin
                $display("%s: port %0d did not alternate between its colour and dark",
                         name, p);
                test_ok = 1'b0;
            end
        end
    endtask

    task automatic report_test(input string name);
        if (test_ok) begin
            pass_cnt++;
            $display("pass  %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL  %s", name);
        end
    endtask

    task automatic check_reset();
        logic       started;
        logic       framed;
        logic [7:0] reply;
        test_ok = 1'b1;
        @(negedge clk_125mhz);
        assert ({led_r, led_g, led_b} == '0) else begin
            $display("Error reset_state: LEDs expected %h actual %h",
                     {3 * PORTS{1'b0}}, {led_r, led_g, led_b});
            test_ok = 1'b0;
        end
        assert (uart_txd === 1'b1) else begin
            $display("Error reset_state: uart_txd expected 1 actual %b", uart_txd);
            test_ok = 1'b0;
        end
        receive_byte(2 * BIT_CYC, started, framed, reply);
        assert (!started) else begin
            $display("reset_state: uart_txd sent a start bit with no command");
            test_ok = 1'b0;
        end
        report_test("reset_state");
    endtask

    task automatic run_test(input int idx);
        logic       started;
        logic       framed;
        logic [7:0] cmd;
        logic [7:0] reply;
        logic [7:0] exp_reply;
        test_ok = 1'b1;
        cmd = t_cmd[idx];
        // Bits 7..6 port, 5 blink, 4..2 colour, 1..0 reserved
        if (cmd[1:0] != 2'b00) begin
            exp_reply = led_pkg::NAK_BYTE;
        end else begin
            exp_reply = cmd;
            m_blink[cmd[7:6]] = cmd[5];
            m_r[cmd[7:6]] = cmd[4];
            m_g[cmd[7:6]] = cmd[3];
            m_b[cmd[7:6]] = cmd[2];
        end
        assert (t_reply[idx] == exp_reply) else begin
            $display("Error %s: data file reply expected %h actual %h",
                     t_name[idx], exp_reply, t_reply[idx]);
            test_ok = 1'b0;
        end
        assert ({t_r[idx], t_g[idx], t_b[idx], t_blink[idx]} == {m_r, m_g, m_b, m_blink})
        else begin
            $display("Error %s: data file state expected %h actual %h", t_name[idx],
                     {m_r, m_g, m_b, m_blink}, {t_r[idx], t_g[idx], t_b[idx], t_blink[idx]});
            test_ok = 1'b0;
        end
        fork
            send_byte(cmd);
            receive_byte(13 * BIT_CYC, started, framed, reply);
        join
        assert (started) else begin
            $display("%s: no reply came back on uart_txd", t_name[idx]);
            test_ok = 1'b0;
        end
        assert (!started || framed) else begin
            $display("%s: the reply frame had a bad start or stop bit", t_name[idx]);
            test_ok = 1'b0;
        end
        assert (!started || reply == t_reply[idx]) else begin
            $display("Error %s: reply expected %h actual %h", t_name[idx], t_reply[idx], reply);
            test_ok = 1'b0;
        end
        check_leds(t_name[idx], t_r[idx], t_g[idx], t_b[idx], t_blink[idx]);
        report_test(t_name[idx]);
        wait_bits(2);
    endtask

    initial begin
        uart_rxd = 1'b1;
        void'($urandom(42062));
        m_r = '0;
        m_g = '0;
        m_b = '0;
        m_blink = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        test_ok = 1'b1;
        load_tests();
        loaded = 1'b1;
        @(posedge rst_n);
        repeat (board_pkg::RST_SYNC_LEN + 2) @(posedge clk_125mhz);
        check_reset();
        for (int i = 0; i < t_name.size(); i++) begin
            run_test(i);
            wait_bits(1 + int'($urandom % 4));
        end
        // All ports together against the model
        test_ok = 1'b1;
        check_leds("final_state", m_r, m_g, m_b, m_blink);
        report_test("final_state");
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog allows about 40 bit times per test
    initial begin
        wait (loaded);
        wd_ns = (t_name.size() + 2) * 40 * BIT_CYC * CLK_PERIOD_NS;
        #(wd_ns);
        $display("Timeout: the tests did not finish within %0d ns", wd_ns);
        $display("Something failed");
        $finish;
    end

endmodule

//--- dv/fpga_testdata.txt
# name  command  reply  red green blue blink
# hex fields, LED columns hold one bit per port with port 0 in bit 0
p0_red_steady     10 10 1 0 0 0
p1_green_steady   48 48 1 2 0 0
p2_blue_steady    84 84 1 2 4 0
p3_white_steady   DC DC 9 A C 0
nak_rsvd_bit0     11 FF 9 A C 0
nak_rsvd_bit1     E2 FF 9 A C 0
p0_blink_yellow   38 38 9 B C 1
p2_blink_magenta  B4 B4 D B C 5
p0_steady_cyan    0C 0C C B D 4
p3_off            C0 C0 4 3 5 4
p1_blink_dark     60 60 4 1 5 6
nak_rsvd_both     7F FF 4 1 5 6
p2_steady_red     90 90 4 1 1 2
p1_white_steady   5C 5C 6 3 3 0
p3_blink_blue     E4 E4 6 3 B 8

//--- build.f
verilog/board_pkg.sv
verilog/led_pkg.sv
verilog/sync_reset.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/fpga_core.sv
verilog/fpga.sv
dv/tb_clk_gen.sv
dv/tb_fpga.sv

//--- Makefile
# Verilator simulation of the network card shell
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_fpga -Mdir obj_dir -f build.f

# The run fails unless the log holds the pass line
run: compile
	./obj_dir/Vtb_fpga | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
